// ==== md_pkg.sv ====
package md_pkg;

    // operand width, fixed by the register file
    localparam int xlen = 32;

    // request opcodes seen by the unit
    typedef enum logic [2:0] {
        md_mult  = 3'd0,
        md_multu = 3'd1,
        md_div   = 3'd2,
        md_divu  = 3'd3,
        md_mthi  = 3'd4,
        md_mtlo  = 3'd5
    } md_op_t;

    // control FSM states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mul  = 2'd1,
        st_div  = 2'd2
    } md_state_t;

    // product: hi is the upper half
    // division: hi is the remainder, lo the quotient
    typedef struct packed {
        logic [xlen-1:0] hi;
        logic [xlen-1:0] lo;
    } md_result_t;

endpackage

// ==== booth_multiplier.sv ====
`timescale 1ns/10ps

module booth_multiplier (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mul_start,
    input  logic                   is_signed,
    input  logic [md_pkg::xlen-1:0] a_val,
    input  logic [md_pkg::xlen-1:0] b_val,
    output logic                   mul_done,
    output md_pkg::md_result_t     mul_res
);

    localparam int w     = md_pkg::xlen;
    // one guard bit so the unsigned form stays positive, one more to round to digits
    localparam int ext_w = w + 2;
    localparam int acc_w = 2 * w + 2;
    localparam int steps = ext_w / 2;

    logic [ext_w-1:0] a_ext;
    logic [ext_w-1:0] b_ext;

    // multiplier with the implied zero below bit 0
    logic [ext_w:0]   mplr;
    // multiplicand already shifted to the current digit position
    logic [acc_w-1:0] mcand;
    logic [acc_w-1:0] acc;
    logic [acc_w-1:0] pp;

    logic [4:0]       step_cnt;
    logic             running;

    always_comb begin
        if (is_signed) begin
            a_ext = {{2{a_val[w-1]}}, a_val};
            b_ext = {{2{b_val[w-1]}}, b_val};
        end else begin
            a_ext = {2'b00, a_val};
            b_ext = {2'b00, b_val};
        end
    end

    // radix-4 recoding of the low triple into 0, +-M or +-2M
    always_comb begin
        case (mplr[2:0])
            3'b001, 3'b010: pp = mcand;
            3'b011:         pp = mcand << 1;
            3'b100:         pp = -(mcand << 1);
            3'b101, 3'b110: pp = -mcand;
            default:        pp = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            mul_done <= 1'b0;
            step_cnt <= '0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 5'd1;
                // last digit added on this edge
                if (step_cnt == 5'(steps - 1)) begin
                    running  <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mplr  <= {a_ext, 1'b0};
            mcand <= {{w{b_ext[ext_w-1]}}, b_ext};
            acc   <= '0;
        end else if (running) begin
            // next triple overlaps the top bit of this one
            mplr  <= mplr >> 2;
            mcand <= mcand << 2;
            acc   <= acc + pp;
        end
    end

    // the two guard bits of the sum are dropped
    assign mul_res = md_pkg::md_result_t'(acc[2*w-1:0]);

    a_no_restart_while_running: assert property (
        @(posedge clk) disable iff (!rst_n)
        running |-> !mul_start
    );

endmodule

// ==== restoring_divider.sv ====
`timescale 1ns/10ps

module restoring_divider (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    div_start,
    input  logic                    is_signed,
    input  logic [md_pkg::xlen-1:0] a_val,
    input  logic [md_pkg::xlen-1:0] b_val,
    output logic                    div_done,
    output md_pkg::md_result_t      div_res
);

    localparam int w = md_pkg::xlen;

    logic [w-1:0] a_mag;
    logic [w-1:0] b_mag;

    // partial remainder, dividend bits turning into quotient bits, divisor
    logic [w-1:0] rem;
    logic [w-1:0] quo;
    logic [w-1:0] dvs;

    logic         neg_q;
    logic         neg_r;
    logic         dvz;

    logic [w:0]   shifted;
    logic [w:0]   diff;

    logic [4:0]   iter_cnt;
    logic         running;
    logic         fix_pend;

    always_comb begin
        a_mag = a_val;
        b_mag = b_val;
        if (is_signed && a_val[w-1]) begin
            a_mag = -a_val;
        end
        if (is_signed && b_val[w-1]) begin
            b_mag = -b_val;
        end
    end

    // trial subtract of the divisor from the shifted remainder
    always_comb begin
        shifted = {rem, quo[w-1]};
        diff    = shifted - {1'b0, dvs};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            fix_pend <= 1'b0;
            div_done <= 1'b0;
            iter_cnt <= '0;
        end else begin
            div_done <= 1'b0;
            fix_pend <= 1'b0;
            if (div_start) begin
                running  <= 1'b1;
                iter_cnt <= '0;
            end else if (running) begin
                iter_cnt <= iter_cnt + 5'd1;
                if (iter_cnt == 5'(w - 1)) begin
                    running  <= 1'b0;
                    fix_pend <= 1'b1;
                end
            end else if (fix_pend) begin
                div_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem   <= '0;
            quo   <= a_mag;
            dvs   <= b_mag;
            neg_q <= is_signed && (a_val[w-1] ^ b_val[w-1]);
            neg_r <= is_signed && a_val[w-1];
            dvz   <= (b_val == '0);
        end else if (running) begin
            if (!diff[w]) begin
                rem <= diff[w-1:0];
                quo <= {quo[w-2:0], 1'b1};
            end else begin
                rem <= shifted[w-1:0];
                quo <= {quo[w-2:0], 1'b0};
            end
        end
    end

    // sign fix; remainder follows the dividend, so a zero divisor
    // returns the dividend there on its own
    always_ff @(posedge clk) begin
        if (fix_pend) begin
            div_res.hi <= neg_r ? -rem : rem;
            if (dvz) begin
                div_res.lo <= '1;
            end else begin
                div_res.lo <= neg_q ? -quo : quo;
            end
        end
    end

    a_no_restart_while_running: assert property (
        @(posedge clk) disable iff (!rst_n)
        (running || fix_pend) |-> !div_start
    );

endmodule

// ==== hilo_control.sv ====
`timescale 1ns/10ps

module hilo_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  md_pkg::md_op_t          op,
    input  logic [md_pkg::xlen-1:0] rs_val,
    input  logic [md_pkg::xlen-1:0] rt_val,
    input  logic                    mul_done,
    input  md_pkg::md_result_t      mul_res,
    input  logic                    div_done,
    input  md_pkg::md_result_t      div_res,
    output logic                    mul_start,
    output logic                    div_start,
    output logic                    is_signed,
    output logic [md_pkg::xlen-1:0] a_val,
    output logic [md_pkg::xlen-1:0] b_val,
    output md_pkg::md_result_t      hilo,
    output logic                    busy
);

    md_pkg::md_state_t state;
    logic              accept;

    assign busy   = (state != md_pkg::st_idle);
    // requests while an engine runs are dropped
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= md_pkg::st_idle;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            hilo      <= '0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            case (state)
                md_pkg::st_idle: begin
                    if (accept) begin
                        case (op)
                            md_pkg::md_mult, md_pkg::md_multu: begin
                                mul_start <= 1'b1;
                                state     <= md_pkg::st_mul;
                            end
                            md_pkg::md_div, md_pkg::md_divu: begin
                                div_start <= 1'b1;
                                state     <= md_pkg::st_div;
                            end
                            // register moves finish at the accepting edge
                            md_pkg::md_mthi: hilo.hi <= rs_val;
                            md_pkg::md_mtlo: hilo.lo <= rs_val;
                            default: ;
                        endcase
                    end
                end
                md_pkg::st_mul: begin
                    if (mul_done) begin
                        hilo  <= mul_res;
                        state <= md_pkg::st_idle;
                    end
                end
                md_pkg::st_div: begin
                    if (div_done) begin
                        hilo  <= div_res;
                        state <= md_pkg::st_idle;
                    end
                end
                default: state <= md_pkg::st_idle;
            endcase
        end
    end

    // operands held for the engines while they run
    always_ff @(posedge clk) begin
        if (accept) begin
            a_val     <= rs_val;
            b_val     <= rt_val;
            is_signed <= (op == md_pkg::md_mult) || (op == md_pkg::md_div);
        end
    end

    a_mul_done_only_when_started: assert property (
        @(posedge clk) disable iff (!rst_n)
        mul_done |-> (state == md_pkg::st_mul)
    );

    a_div_done_only_when_started: assert property (
        @(posedge clk) disable iff (!rst_n)
        div_done |-> (state == md_pkg::st_div)
    );

endmodule

// ==== mul_div_unit.sv ====
`timescale 1ns/10ps

module mul_div_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  md_pkg::md_op_t          op,
    input  logic [md_pkg::xlen-1:0] rs_val,
    input  logic [md_pkg::xlen-1:0] rt_val,
    output md_pkg::md_result_t      hilo,
    output logic                    busy
);

    logic                    mul_start;
    logic                    div_start;
    logic                    is_signed;
    logic [md_pkg::xlen-1:0] a_val;
    logic [md_pkg::xlen-1:0] b_val;
    logic                    mul_done;
    logic                    div_done;
    md_pkg::md_result_t      mul_res;
    md_pkg::md_result_t      div_res;

    hilo_control u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .op        (op),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .mul_done  (mul_done),
        .mul_res   (mul_res),
        .div_done  (div_done),
        .div_res   (div_res),
        .mul_start (mul_start),
        .div_start (div_start),
        .is_signed (is_signed),
        .a_val     (a_val),
        .b_val     (b_val),
        .hilo      (hilo),
        .busy      (busy)
    );

    booth_multiplier u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .is_signed (is_signed),
        .a_val     (a_val),
        .b_val     (b_val),
        .mul_done  (mul_done),
        .mul_res   (mul_res)
    );

    restoring_divider u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_start (div_start),
        .is_signed (is_signed),
        .a_val     (a_val),
        .b_val     (b_val),
        .div_done  (div_done),
        .div_res   (div_res)
    );

endmodule

// ==== tb_md_model.svh ====
`ifndef TB_MD_MODEL_SVH
`define TB_MD_MODEL_SVH

// 32-bit xorshift, state lives in the testbench module
function automatic logic [w-1:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

// expected HI/LO after one request, given the HI/LO before it
function automatic md_pkg::md_result_t md_model(input md_pkg::md_op_t req_op,
                                                 input logic [w-1:0] a,
                                                 input logic [w-1:0] b,
                                                 input md_pkg::md_result_t prev);
    md_pkg::md_result_t res;
    logic [2*w-1:0]     prod;
    logic signed [w-1:0] sa;
    logic signed [w-1:0] sb;
    res = prev;
    sa  = a;
    sb  = b;
    case (req_op)
        md_pkg::md_mult: begin
            prod   = {{w{a[w-1]}}, a} * {{w{b[w-1]}}, b};
            res.hi = prod[2*w-1:w];
            res.lo = prod[w-1:0];
        end
        md_pkg::md_multu: begin
            prod   = {{w{1'b0}}, a} * {{w{1'b0}}, b};
            res.hi = prod[2*w-1:w];
            res.lo = prod[w-1:0];
        end
        md_pkg::md_div: begin
            if (b == '0) begin
                res.hi = a;
                res.lo = '1;
            end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                // overflow case keeps the dividend as quotient
                res.hi = '0;
                res.lo = a;
            end else begin
                res.hi = sa % sb;
                res.lo = sa / sb;
            end
        end
        md_pkg::md_divu: begin
            if (b == '0) begin
                res.hi = a;
                res.lo = '1;
            end else begin
                res.hi = a % b;
                res.lo = a / b;
            end
        end
        md_pkg::md_mthi: res.hi = a;
        md_pkg::md_mtlo: res.lo = a;
        default: ;
    endcase
    return res;
endfunction

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("ERR %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
    end
endtask

`endif

// ==== tb_mul_div_unit.sv ====
`timescale 1ns/10ps

module tb_mul_div_unit;

    localparam int w = md_pkg::xlen;
    // about 250 multiplies at 21 cycles and 230 divides at 37 cycles, plus margin
    localparam int max_cycles = 20000;

    logic               clk;
    logic               rst_n;
    logic               start;
    md_pkg::md_op_t     op;
    logic [w-1:0]       rs_val;
    logic [w-1:0]       rt_val;
    md_pkg::md_result_t hilo;
    logic               busy;

    logic [w-1:0]       rng_state = 32'd71;
    int                 err_cnt = 0;
    int                 check_cnt = 0;
    int                 test_cnt = 0;
    int                 test_err_base = 0;
    int                 test_chk_base = 0;
    int                 cycle_cnt = 0;

    // expected results handed from stimulus to the compare process
    md_pkg::md_result_t exp_q[$];
    md_pkg::md_result_t model_hilo;
    int                 issued = 0;
    int                 compared = 0;

    `include "tb_md_model.svh"

    mul_div_unit UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .hilo   (hilo),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= max_cycles);
        $display("timeout: tests still running after %0d cycles", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    function automatic int op_latency(input md_pkg::md_op_t req_op);
        case (req_op)
            md_pkg::md_mult, md_pkg::md_multu: return 19;
            md_pkg::md_div, md_pkg::md_divu:   return 35;
            default:                           return 0;
        endcase
    endfunction

    task automatic run_op(input md_pkg::md_op_t req_op, input logic [w-1:0] a,
                          input logic [w-1:0] b, input logic poke,
                          input md_pkg::md_op_t poke_op);
        md_pkg::md_result_t exp_res;
        int                 lat;
        int                 i;
        exp_res = md_model(req_op, a, b, model_hilo);
        lat     = op_latency(req_op);
        @(negedge clk);
        start  = 1'b1;
        op     = req_op;
        rs_val = a;
        rt_val = b;
        @(negedge clk);
        start = 1'b0;
        // old HI/LO must hold and busy stay high until the fixed latency
        for (i = 0; i < lat; i++) begin
            check_val("busy", {63'd0, busy}, 64'd1);
            check_val("hilo", hilo, model_hilo);
            // second request while busy, should be dropped
            if (poke && i == 3) begin
                start  = 1'b1;
                op     = poke_op;
                rs_val = next_rand();
                rt_val = next_rand();
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
        end
        start      = 1'b0;
        model_hilo = exp_res;
        exp_q.push_back(exp_res);
        issued++;
        wait (compared == issued);
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
                 check_cnt - test_chk_base, err_cnt - test_err_base);
        test_chk_base = check_cnt;
        test_err_base = err_cnt;
    endtask

    // compare process
    initial begin
        md_pkg::md_result_t exp_res;
        forever begin
            wait (issued > compared);
            exp_res = exp_q.pop_front();
            check_val("hilo", hilo, exp_res);
            check_val("busy", {63'd0, busy}, 64'd0);
            compared++;
        end
    end

    initial begin
        int           i;
        int           j;
        logic [w-1:0] a;
        logic [w-1:0] b;
        logic [w-1:0] sh;
        logic [w-1:0] mc [5];
        logic [w-1:0] da [4];
        logic [w-1:0] db [3];
        rst_n      = 1'b0;
        start      = 1'b0;
        op         = md_pkg::md_mult;
        rs_val     = '0;
        rt_val     = '0;
        model_hilo = '0;
        mc[0] = 32'h0000_0000;
        mc[1] = 32'h0000_0001;
        mc[2] = 32'hffff_ffff;
        mc[3] = 32'h8000_0000;
        mc[4] = 32'h7fff_ffff;
        da[0] = 32'd7;
        da[1] = 32'hffff_fff9;
        da[2] = 32'h7fff_ffff;
        da[3] = 32'h8000_0000;
        db[0] = 32'd2;
        db[1] = 32'hffff_fffe;
        db[2] = 32'd3;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_val("hilo", hilo, 64'd0);
        check_val("busy", {63'd0, busy}, 64'd0);
        for (i = 0; i < 3; i++) begin
            run_op(md_pkg::md_mthi, next_rand(), next_rand(), 1'b0, md_pkg::md_mult);
            run_op(md_pkg::md_mtlo, next_rand(), next_rand(), 1'b0, md_pkg::md_mult);
        end
        report_test("reset and register moves");

        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 5; j++) begin
                run_op(md_pkg::md_mult, mc[i], mc[j], 1'b0, md_pkg::md_mult);
                run_op(md_pkg::md_multu, mc[i], mc[j], 1'b0, md_pkg::md_mult);
            end
        end
        for (i = 0; i < 100; i++) begin
            run_op(md_pkg::md_mult, next_rand(), next_rand(), 1'b0, md_pkg::md_mult);
            run_op(md_pkg::md_multu, next_rand(), next_rand(), 1'b0, md_pkg::md_mult);
        end
        report_test("signed and unsigned multiply");

        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 3; j++) begin
                run_op(md_pkg::md_div, da[i], db[j], 1'b0, md_pkg::md_mult);
                run_op(md_pkg::md_divu, da[i], db[j], 1'b0, md_pkg::md_mult);
            end
        end
        for (i = 0; i < 100; i++) begin
            // shorter divisors give quotients of every size
            a  = next_rand();
            sh = next_rand();
            b  = next_rand() >> sh[4:0];
            run_op(md_pkg::md_div, a, b, 1'b0, md_pkg::md_mult);
            run_op(md_pkg::md_divu, a, b, 1'b0, md_pkg::md_mult);
        end
        report_test("signed and unsigned divide");

        run_op(md_pkg::md_div, 32'h1234_5678, 32'h0, 1'b0, md_pkg::md_mult);
        run_op(md_pkg::md_div, 32'hfedc_ba98, 32'h0, 1'b0, md_pkg::md_mult);
        run_op(md_pkg::md_divu, 32'h8765_4321, 32'h0, 1'b0, md_pkg::md_mult);
        run_op(md_pkg::md_div, 32'h8000_0000, 32'hffff_ffff, 1'b0, md_pkg::md_mult);
        run_op(md_pkg::md_divu, 32'h8000_0000, 32'hffff_ffff, 1'b0, md_pkg::md_mult);
        report_test("special divides");

        run_op(md_pkg::md_mult, next_rand(), next_rand(), 1'b1, md_pkg::md_div);
        run_op(md_pkg::md_multu, next_rand(), next_rand(), 1'b0, md_pkg::md_mult);
        run_op(md_pkg::md_div, next_rand(), 32'h0000_1234, 1'b1, md_pkg::md_mthi);
        run_op(md_pkg::md_divu, next_rand(), 32'h0000_0567, 1'b0, md_pkg::md_mult);
        report_test("start while busy");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
md_pkg.sv
booth_multiplier.sv
restoring_divider.sv
hilo_control.sv
mul_div_unit.sv
tb_mul_div_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mul/div unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_mul_div_unit
log=sim.log

verilator --binary --timing --assert -f sim.f --top-module "$top" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
